//--- list.f
src/opf_pkg.sv
src/cmd_fetch.sv
src/operand_fetch.sv
src/reg_file.sv
src/bus_arbiter.sv
src/mem_manager.sv
bench/wb_slave_model.sv
bench/tb_mem_manager.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_manager
RTL_TOP   ?= mem_manager
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
RTL       ?= src/opf_pkg.sv src/cmd_fetch.sv src/operand_fetch.sv src/reg_file.sv \
             src/bus_arbiter.sv src/mem_manager.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_mem_manager.sv
`timescale 1ns/10ps

module tb_mem_manager;

  localparam int          period    = 8;
  localparam int          timeout   = 400;
  localparam logic [31:0] seed      = 32'hbc58_0a01;
  localparam int          mem_depth = 1024;
  localparam int          addr_w    = 16;
  localparam logic [15:0] code_at   = 16'h0100;
  localparam logic [15:0] data_at   = 16'h0200;

  logic                          clk;
  logic                          rst;
  logic                          run;
  logic [addr_w-1:0]             code_base;
  logic [addr_w-1:0]             data_base;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic [addr_w-1:0]             wb_adr;
  logic [opf_pkg::data_w-1:0]    wb_rdata;
  logic                          wb_ack;
  logic                          wb_en;
  logic [opf_pkg::reg_num_w-1:0] wb_num;
  logic [opf_pkg::data_w-1:0]    wb_data;
  logic                          op_valid;
  logic                          op_ready;
  logic [opf_pkg::code_w-1:0]    op_code;
  logic [opf_pkg::data_w-1:0]    op_src1;
  logic [opf_pkg::data_w-1:0]    op_src0;
  logic [opf_pkg::reg_num_w-1:0] op_dst;

  // reference register state
  // r15 is never stored here
  logic [31:0] model_regs [0:15];
  logic [31:0] prog [0:31];
  int          prog_len;
  int          test_errors = 0;
  int          fail_checks = 0;
  int          tests_run = 0;
  int          tests_ok = 0;
  logic        timed_out = 1'b0;
  logic [31:0] rnd = seed;
  string       cur_test = "setup";

  // last bus cycle as the protocol monitor saw it
  logic              bus_open = 1'b0;
  logic              bus_acked = 1'b0;
  logic [addr_w-1:0] bus_adr = '0;

  mem_manager #(.addr_w(addr_w)) mem_manager_i (
    .clk(clk), .rst(rst), .run(run), .code_base(code_base), .data_base(data_base),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr), .wb_rdata(wb_rdata), .wb_ack(wb_ack),
    .wb_en(wb_en), .wb_num(wb_num), .wb_data(wb_data),
    .op_valid(op_valid), .op_ready(op_ready), .op_code(op_code),
    .op_src1(op_src1), .op_src0(op_src0), .op_dst(op_dst)
  );

  wb_slave_model #(.addr_w(addr_w), .depth(mem_depth), .seed(seed)) mem_model_i (
    .clk(clk), .rst(rst), .cyc(wb_cyc), .stb(wb_stb), .adr(wb_adr),
    .rdata(wb_rdata), .ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory fill pattern
  // every address bit shows in the word
  function automatic logic [31:0] data_word(input logic [15:0] a);
    return {a, ~a} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] make_cmd(input logic [3:0] code, input logic [3:0] dst,
      input logic [3:0] s0, input logic [3:0] s1, input logic p0, input logic p1,
      input logic [1:0] f0, input logic [1:0] f1);
    logic [31:0] w;
    w = 32'h0;
    w[opf_pkg::code_lsb +: opf_pkg::code_w] = code;
    w[opf_pkg::d_lsb +: 4] = dst;
    w[opf_pkg::s0_lsb +: 4] = s0;
    w[opf_pkg::s1_lsb +: 4] = s1;
    w[opf_pkg::s0_ptr_bit] = p0;
    w[opf_pkg::s1_ptr_bit] = p1;
    w[opf_pkg::s0_flag_lsb +: 2] = f0;
    w[opf_pkg::s1_flag_lsb +: 2] = f1;
    return w;
  endfunction

  task automatic check_value(input string test, input string what,
      input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s %s expected %h actual %h", test, what, exp, act);
      test_errors++;
    end
  endtask

  // wishbone classic rules on the master side
  always @(posedge clk) begin
    if (rst !== 1'b0) begin
      bus_open  = 1'b0;
      bus_acked = 1'b0;
    end else begin
      check_value(cur_test, "stb with cyc", 32'(wb_cyc), 32'(wb_stb));
      // open cycle keeps cyc and the address until ack
      if (bus_open) begin
        check_value(cur_test, "cyc held", 32'd1, 32'(wb_cyc));
        check_value(cur_test, "adr held", 32'(bus_adr), 32'(wb_adr));
      end
      // cyc drops right after the ack cycle
      if (bus_acked) begin
        check_value(cur_test, "cyc after ack", 32'd0, 32'(wb_cyc));
      end
      bus_open  = wb_cyc && !wb_ack;
      bus_acked = wb_cyc && wb_ack;
      bus_adr   = wb_adr;
    end
  end

  // resolves one source by the plain rules
  // step applied after the read
  task automatic model_source(input logic [3:0] num, input logic ptr, input logic [1:0] flag,
      input int k, output logic [31:0] res);
    logic [31:0] val;
    logic [15:0] a;
    // r15 is the offset of the command after this one
    val = (num == 4'd15) ? 32'(k + 1) : model_regs[num];
    a = data_at + val[15:0];
    res = ptr ? data_word(a) : val;
    if (num != 4'd15 && flag == 2'b01) begin
      model_regs[num] = val + 32'd1;
    end else if (num != 4'd15 && flag == 2'b10) begin
      model_regs[num] = val - 32'd1;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    run <= 1'b0;
    wb_en <= 1'b0;
    op_ready <= 1'b1;
    repeat (2) @(posedge clk);
    // values seen here come from the reset cycle
    check_value(cur_test, "valid after reset", 32'd0, 32'(op_valid));
    check_value(cur_test, "cyc after reset", 32'd0, 32'(wb_cyc));
    rst <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = 32'h0;
    end
  endtask

  // loads one register through write-back while run is low
  task automatic load_reg(input logic [3:0] num, input logic [31:0] val);
    @(posedge clk);
    wb_en <= 1'b1;
    wb_num <= num;
    wb_data <= val;
    @(posedge clk);
    wb_en <= 1'b0;
    model_regs[num] = val;
  endtask

  task automatic run_program(input logic stall);
    logic [31:0] w;
    logic [31:0] e_src1;
    logic [31:0] e_src0;
    logic [31:0] held_vals [0:3];
    logic        held;
    logic        done;
    int          waited;
    // zero words after the program soak up fetch run-ahead
    for (int k = 0; k < prog_len + 4; k++) begin
      mem_model_i.mem[10'(code_at + 16'(k))] = (k < prog_len) ? prog[k] : 32'h0;
    end
    held = 1'b0;
    @(posedge clk);
    run <= 1'b1;
    for (int k = 0; k < prog_len && !timed_out; k++) begin
      w = prog[k];
      // src1 first, so src0 sees its step
      model_source(w[opf_pkg::s1_lsb +: 4], w[opf_pkg::s1_ptr_bit],
                   w[opf_pkg::s1_flag_lsb +: 2], k, e_src1);
      model_source(w[opf_pkg::s0_lsb +: 4], w[opf_pkg::s0_ptr_bit],
                   w[opf_pkg::s0_flag_lsb +: 2], k, e_src0);
      done = 1'b0;
      waited = 0;
      while (!done && !timed_out) begin
        @(posedge clk);
        // outputs must not move after a stalled cycle
        if (held) begin
          check_value(cur_test, "valid held", 32'd1, 32'(op_valid));
          check_value(cur_test, "code held", held_vals[0], 32'(op_code));
          check_value(cur_test, "src1 held", held_vals[1], op_src1);
          check_value(cur_test, "src0 held", held_vals[2], op_src0);
          check_value(cur_test, "dst held", held_vals[3], 32'(op_dst));
        end
        held_vals[0] = 32'(op_code);
        held_vals[1] = op_src1;
        held_vals[2] = op_src0;
        held_vals[3] = 32'(op_dst);
        held = op_valid && !op_ready;
        if (op_valid && op_ready) begin
          done = 1'b1;
        end else if (waited == timeout) begin
          $display("timeout waiting for command %0d to issue in test %s", k, cur_test);
          timed_out = 1'b1;
        end
        waited++;
        if (stall) begin
          rnd = lcg_step(rnd);
          op_ready <= rnd[19];
        end
      end
      if (done) begin
        check_value(cur_test, "code", 32'(w[opf_pkg::code_lsb +: opf_pkg::code_w]),
                    32'(op_code));
        check_value(cur_test, "dst", 32'(w[opf_pkg::d_lsb +: 4]), 32'(op_dst));
        check_value(cur_test, "src1", e_src1, op_src1);
        check_value(cur_test, "src0", e_src0, op_src0);
      end
    end
    run <= 1'b0;
    op_ready <= 1'b1;
    tests_run++;
    fail_checks += test_errors;
    if (timed_out) begin
      $display("%s stopped by a timeout", cur_test);
    end else if (test_errors == 0) begin
      tests_ok++;
      $display("%s ok, %0d commands", cur_test, prog_len);
    end else begin
      $display("%s has %0d mismatches", cur_test, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic direct_operands();
    cur_test = "direct";
    apply_reset();
    for (int i = 0; i < 15; i++) begin
      load_reg(4'(i), 32'h1111_0000 + 32'(i * 9));
    end
    prog_len = 8;
    for (int k = 0; k < 8; k++) begin
      prog[k] = make_cmd(4'(k + 1), 4'(k), 4'((k * 3) % 15), 4'((k * 5 + 1) % 15),
                         1'b0, 1'b0, 2'b00, 2'b00);
    end
    run_program(1'b0);
  endtask

  task automatic pointer_operands();
    cur_test = "pointer";
    apply_reset();
    for (int i = 0; i < 15; i++) begin
      load_reg(4'(i), 32'(i * 11 + 5));
    end
    prog_len = 8;
    for (int k = 0; k < 8; k++) begin
      prog[k] = make_cmd(4'(15 - k), 4'(k + 2), 4'((k * 7 + 3) % 15), 4'((k * 2) % 15),
                         1'b1, 1'b1, 2'b00, 2'b00);
    end
    run_program(1'b0);
  endtask

  task automatic step_flags();
    cur_test = "steps";
    apply_reset();
    for (int i = 0; i < 15; i++) begin
      load_reg(4'(i), 32'(100 + i));
    end
    prog_len = 7;
    prog[0] = make_cmd(4'd1, 4'd2, 4'd3, 4'd3, 1'b0, 1'b0, 2'b01, 2'b01);
    prog[1] = make_cmd(4'd2, 4'd3, 4'd3, 4'd4, 1'b0, 1'b0, 2'b10, 2'b10);
    prog[2] = make_cmd(4'd3, 4'd4, 4'd5, 4'd5, 1'b1, 1'b1, 2'b10, 2'b01);
    prog[3] = make_cmd(4'd4, 4'd5, 4'd6, 4'd6, 1'b0, 1'b0, 2'b11, 2'b11);
    prog[4] = make_cmd(4'd5, 4'd6, 4'd4, 4'd3, 1'b0, 1'b0, 2'b00, 2'b00);
    prog[5] = make_cmd(4'd6, 4'd7, 4'd5, 4'd6, 1'b1, 1'b0, 2'b01, 2'b10);
    prog[6] = make_cmd(4'd7, 4'd8, 4'd6, 4'd5, 1'b0, 1'b1, 2'b00, 2'b00);
    run_program(1'b0);
  endtask

  task automatic ip_register();
    cur_test = "ip_reg";
    apply_reset();
    load_reg(4'd1, 32'h0000_0040);
    load_reg(4'd2, 32'h0000_0013);
    prog_len = 5;
    prog[0] = make_cmd(4'd1, 4'd0, 4'd15, 4'd15, 1'b0, 1'b0, 2'b10, 2'b01);
    prog[1] = make_cmd(4'd2, 4'd1, 4'd1, 4'd15, 1'b0, 1'b1, 2'b00, 2'b00);
    prog[2] = make_cmd(4'd3, 4'd2, 4'd15, 4'd1, 1'b0, 1'b0, 2'b01, 2'b00);
    prog[3] = make_cmd(4'd4, 4'd15, 4'd2, 4'd15, 1'b1, 1'b0, 2'b00, 2'b11);
    prog[4] = make_cmd(4'd5, 4'd3, 4'd15, 4'd15, 1'b0, 1'b0, 2'b00, 2'b00);
    run_program(1'b0);
  endtask

  task automatic back_pressure();
    cur_test = "backpressure";
    apply_reset();
    for (int i = 0; i < 15; i++) begin
      load_reg(4'(i), 32'(i * 5 + 20));
    end
    prog_len = 16;
    for (int k = 0; k < 16; k++) begin
      prog[k] = make_cmd(4'(k), 4'(15 - k), 4'((k * 6 + 2) % 16), 4'((k * 4 + 1) % 15),
                         k[1], k[0], 2'(k >> 2), 2'(k));
    end
    run_program(1'b1);
  endtask

  initial begin
    rst <= 1'b1;
    run <= 1'b0;
    code_base <= code_at;
    data_base <= data_at;
    wb_en <= 1'b0;
    wb_num <= 4'd0;
    wb_data <= 32'h0;
    op_ready <= 1'b1;
    for (int a = 0; a < mem_depth; a++) begin
      mem_model_i.mem[a] = data_word(16'(a));
    end
    direct_operands();
    if (!timed_out) pointer_operands();
    if (!timed_out) step_flags();
    if (!timed_out) ip_register();
    if (!timed_out) back_pressure();
    $display("tests run %0d, ok %0d, failed checks %0d", tests_run, tests_ok, fail_checks);
    if (fail_checks == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- bench/wb_slave_model.sv
`timescale 1ns/10ps

module wb_slave_model #(
  parameter int          addr_w = 16,
  parameter int          depth  = 1024,
  parameter logic [31:0] seed   = 32'hbc58_0a01
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic [addr_w-1:0]          adr,
  output logic [opf_pkg::data_w-1:0] rdata,
  output logic                       ack
);

  localparam int idx_w = $clog2(depth);

  // filled by the testbench through a hierarchical path
  logic [opf_pkg::data_w-1:0] mem [0:depth-1];
  // lcg state, picks the wait cycles of the next response
  logic [31:0]                rnd = seed;
  logic [1:0]                 wait_cnt;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // classic read, ack for a single cycle after 0 to 3 waits
  always @(posedge clk) begin
    if (rst) begin
      ack      <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (cyc && stb && !ack) begin
      if (wait_cnt == 2'd0) begin
        ack      <= 1'b1;
        rdata    <= mem[adr[idx_w-1:0]];
        rnd      <= lcg_step(rnd);
        wait_cnt <= rnd[17:16];
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else begin
      // master drops cyc the cycle after ack
      ack <= 1'b0;
    end
  end

endmodule

//--- src/mem_manager.sv
`timescale 1ns/10ps

module mem_manager #(
  parameter int addr_w = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          run,
  input  logic [addr_w-1:0]             code_base,
  input  logic [addr_w-1:0]             data_base,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic [addr_w-1:0]             wb_adr,
  input  logic [opf_pkg::data_w-1:0]    wb_rdata,
  input  logic                          wb_ack,
  input  logic                          wb_en,
  input  logic [opf_pkg::reg_num_w-1:0] wb_num,
  input  logic [opf_pkg::data_w-1:0]    wb_data,
  output logic                          op_valid,
  input  logic                          op_ready,
  output logic [opf_pkg::code_w-1:0]    op_code,
  output logic [opf_pkg::data_w-1:0]    op_src1,
  output logic [opf_pkg::data_w-1:0]    op_src0,
  output logic [opf_pkg::reg_num_w-1:0] op_dst
);

  // fetch to operand stage
  logic                          cmd_valid;
  logic                          cmd_ready;
  logic [opf_pkg::data_w-1:0]    cmd_word;
  logic [opf_pkg::data_w-1:0]    cmd_ip;

  // requesters to arbiter
  logic                          f_req;
  logic [addr_w-1:0]             f_addr;
  logic                          f_ack;
  logic [opf_pkg::data_w-1:0]    f_rdata;
  logic                          o_req;
  logic [addr_w-1:0]             o_addr;
  logic                          o_ack;
  logic [opf_pkg::data_w-1:0]    o_rdata;

  // register file ports
  logic [opf_pkg::reg_num_w-1:0] rd_a;
  logic [opf_pkg::reg_num_w-1:0] rd_b;
  logic [opf_pkg::data_w-1:0]    val_a;
  logic [opf_pkg::data_w-1:0]    val_b;
  logic                          upd_en;
  logic [opf_pkg::reg_num_w-1:0] upd_num;
  logic [opf_pkg::data_w-1:0]    upd_data;

  cmd_fetch #(.addr_w(addr_w)) cmd_fetch_i (
    .clk(clk), .rst(rst), .run(run), .code_base(code_base),
    .f_req(f_req), .f_addr(f_addr), .f_ack(f_ack), .f_rdata(f_rdata),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_word(cmd_word), .cmd_ip(cmd_ip)
  );

  operand_fetch #(.addr_w(addr_w)) operand_fetch_i (
    .clk(clk), .rst(rst), .data_base(data_base),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_word(cmd_word), .cmd_ip(cmd_ip),
    .rd_a(rd_a), .rd_b(rd_b), .val_a(val_a), .val_b(val_b),
    .upd_en(upd_en), .upd_num(upd_num), .upd_data(upd_data),
    .o_req(o_req), .o_addr(o_addr), .o_ack(o_ack), .o_rdata(o_rdata),
    .op_valid(op_valid), .op_ready(op_ready), .op_code(op_code),
    .op_src1(op_src1), .op_src0(op_src0), .op_dst(op_dst)
  );

  reg_file reg_file_i (
    .clk(clk), .rst(rst), .rd_a(rd_a), .rd_b(rd_b), .val_a(val_a), .val_b(val_b),
    .upd_en(upd_en), .upd_num(upd_num), .upd_data(upd_data),
    .wb_en(wb_en), .wb_num(wb_num), .wb_data(wb_data)
  );

  bus_arbiter #(.addr_w(addr_w)) bus_arbiter_i (
    .clk(clk), .rst(rst),
    .f_req(f_req), .f_addr(f_addr), .f_ack(f_ack), .f_rdata(f_rdata),
    .o_req(o_req), .o_addr(o_addr), .o_ack(o_ack), .o_rdata(o_rdata),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_rdata(wb_rdata), .wb_ack(wb_ack)
  );

endmodule

//--- src/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter #(
  parameter int addr_w = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       f_req,
  input  logic [addr_w-1:0]          f_addr,
  output logic                       f_ack,
  output logic [opf_pkg::data_w-1:0] f_rdata,
  input  logic                       o_req,
  input  logic [addr_w-1:0]          o_addr,
  output logic                       o_ack,
  output logic [opf_pkg::data_w-1:0] o_rdata,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic [addr_w-1:0]          wb_adr,
  input  logic [opf_pkg::data_w-1:0] wb_rdata,
  input  logic                       wb_ack
);

  // one-hot grant, both low when the bus is idle
  logic gnt_f;
  logic gnt_o;

  // cyc and stb follow the grant, so they drop the cycle after ack
  assign wb_cyc = gnt_f | gnt_o;
  assign wb_stb = gnt_f | gnt_o;
  assign wb_adr = gnt_o ? o_addr : f_addr;

  // ack and data steered to the owner only
  assign f_ack   = wb_ack & gnt_f;
  assign o_ack   = wb_ack & gnt_o;
  assign f_rdata = gnt_f ? wb_rdata : '0;
  assign o_rdata = gnt_o ? wb_rdata : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      gnt_f <= 1'b0;
      gnt_o <= 1'b0;
    end else if (!wb_cyc) begin
      // operand side first, it serves the older command
      if (o_req) begin
        gnt_o <= 1'b1;
      end else if (f_req) begin
        gnt_f <= 1'b1;
      end
    end else if (wb_ack) begin
      gnt_f <= 1'b0;
      gnt_o <= 1'b0;
    end
  end

endmodule

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [opf_pkg::reg_num_w-1:0] rd_a,
  input  logic [opf_pkg::reg_num_w-1:0] rd_b,
  output logic [opf_pkg::data_w-1:0]    val_a,
  output logic [opf_pkg::data_w-1:0]    val_b,
  input  logic                          upd_en,
  input  logic [opf_pkg::reg_num_w-1:0] upd_num,
  input  logic [opf_pkg::data_w-1:0]    upd_data,
  input  logic                          wb_en,
  input  logic [opf_pkg::reg_num_w-1:0] wb_num,
  input  logic [opf_pkg::data_w-1:0]    wb_data
);

  // r0..r14 only, r15 is the ip and lives in the fetch path
  logic [opf_pkg::data_w-1:0] regs [0:opf_pkg::reg_ip-1];

  // combinational reads, r15 reads zero here
  assign val_a = (rd_a == opf_pkg::reg_ip) ? '0 : regs[rd_a];
  assign val_b = (rd_b == opf_pkg::reg_ip) ? '0 : regs[rd_b];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < int'(opf_pkg::reg_ip); i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (upd_en && upd_num != opf_pkg::reg_ip) begin
        regs[upd_num] <= upd_data;
      end
      // later assignment wins, so write-back beats a step on the same reg
      if (wb_en && wb_num != opf_pkg::reg_ip) begin
        regs[wb_num] <= wb_data;
      end
    end
  end

endmodule

//--- src/operand_fetch.sv
`timescale 1ns/10ps

module operand_fetch #(
  parameter int addr_w = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [addr_w-1:0]             data_base,
  input  logic                          cmd_valid,
  output logic                          cmd_ready,
  input  logic [opf_pkg::data_w-1:0]    cmd_word,
  input  logic [opf_pkg::data_w-1:0]    cmd_ip,
  output logic [opf_pkg::reg_num_w-1:0] rd_a,
  output logic [opf_pkg::reg_num_w-1:0] rd_b,
  input  logic [opf_pkg::data_w-1:0]    val_a,
  input  logic [opf_pkg::data_w-1:0]    val_b,
  output logic                          upd_en,
  output logic [opf_pkg::reg_num_w-1:0] upd_num,
  output logic [opf_pkg::data_w-1:0]    upd_data,
  output logic                          o_req,
  output logic [addr_w-1:0]             o_addr,
  input  logic                          o_ack,
  input  logic [opf_pkg::data_w-1:0]    o_rdata,
  output logic                          op_valid,
  input  logic                          op_ready,
  output logic [opf_pkg::code_w-1:0]    op_code,
  output logic [opf_pkg::data_w-1:0]    op_src1,
  output logic [opf_pkg::data_w-1:0]    op_src0,
  output logic [opf_pkg::reg_num_w-1:0] op_dst
);

  localparam logic [1:0] st_take  = 2'd0;
  localparam logic [1:0] st_src1  = 2'd1;
  localparam logic [1:0] st_src0  = 2'd2;
  localparam logic [1:0] st_issue = 2'd3;

  logic [1:0]                    state;
  // command and its next-command offset, held until issue
  logic [opf_pkg::data_w-1:0]    word_r;
  logic [opf_pkg::data_w-1:0]    ip_r;

  // the source being resolved in this state
  logic                          on_src;
  logic [opf_pkg::reg_num_w-1:0] cur_num;
  logic                          cur_ptr;
  logic [1:0]                    cur_flag;
  logic [opf_pkg::data_w-1:0]    cur_val;
  logic [opf_pkg::data_w-1:0]    cur_res;
  logic                          cur_done;

  // field split
  assign rd_a = word_r[opf_pkg::s1_lsb +: opf_pkg::reg_num_w];
  assign rd_b = word_r[opf_pkg::s0_lsb +: opf_pkg::reg_num_w];

  assign cmd_ready = (state == st_take);
  assign op_valid  = (state == st_issue);

  always_comb begin
    on_src = (state == st_src1) || (state == st_src0);
    if (state == st_src0) begin
      cur_num  = rd_b;
      cur_ptr  = word_r[opf_pkg::s0_ptr_bit];
      cur_flag = word_r[opf_pkg::s0_flag_lsb +: 2];
      cur_val  = val_b;
    end else begin
      cur_num  = rd_a;
      cur_ptr  = word_r[opf_pkg::s1_ptr_bit];
      cur_flag = word_r[opf_pkg::s1_flag_lsb +: 2];
      cur_val  = val_a;
    end
    // r15 gives the offset of the following command
    if (cur_num == opf_pkg::reg_ip) begin
      cur_val = ip_r;
    end
    cur_res  = cur_ptr ? o_rdata : cur_val;
    // direct operand in one cycle, pointer operand at the bus ack
    cur_done = on_src && (!cur_ptr || o_ack);
  end

  // pointer read at data_base plus register value
  assign o_req  = on_src && cur_ptr;
  assign o_addr = data_base + cur_val[addr_w-1:0];

  // post step written back when the operand resolves, none on r15
  assign upd_en   = cur_done && (cur_num != opf_pkg::reg_ip) &&
                    (cur_flag == opf_pkg::flag_inc || cur_flag == opf_pkg::flag_dec);
  assign upd_num  = cur_num;
  assign upd_data = (cur_flag == opf_pkg::flag_inc) ? cur_val + opf_pkg::data_w'(1)
                                                    : cur_val - opf_pkg::data_w'(1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_take;
    end else begin
      case (state)
        st_take:  if (cmd_valid) state <= st_src1;
        st_src1:  if (cur_done) state <= st_src0;
        st_src0:  if (cur_done) state <= st_issue;
        default:  if (op_ready) state <= st_take;
      endcase
    end
  end

  // payload, frozen while waiting in issue
  always_ff @(posedge clk) begin
    if (cmd_ready && cmd_valid) begin
      word_r  <= cmd_word;
      ip_r    <= cmd_ip;
      op_code <= cmd_word[opf_pkg::code_lsb +: opf_pkg::code_w];
      op_dst  <= cmd_word[opf_pkg::d_lsb +: opf_pkg::reg_num_w];
    end
    if (cur_done && state == st_src1) begin
      op_src1 <= cur_res;
    end
    if (cur_done && state == st_src0) begin
      op_src0 <= cur_res;
    end
  end

endmodule

//--- src/cmd_fetch.sv
`timescale 1ns/10ps

module cmd_fetch #(
  parameter int addr_w = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic [addr_w-1:0]          code_base,
  output logic                       f_req,
  output logic [addr_w-1:0]          f_addr,
  input  logic                       f_ack,
  input  logic [opf_pkg::data_w-1:0] f_rdata,
  output logic                       cmd_valid,
  input  logic                       cmd_ready,
  output logic [opf_pkg::data_w-1:0] cmd_word,
  output logic [opf_pkg::data_w-1:0] cmd_ip
);

  // instruction pointer, counts command words
  logic [opf_pkg::data_w-1:0] ip;
  // request raised and not yet acked
  logic                       pend;

  // new fetch only if the buffer is empty or being taken
  // pend keeps req up until the ack even if run drops
  assign f_req = pend | (run & (~cmd_valid | cmd_ready));

  // ip only moves on the ack, so the address holds for the whole cycle
  assign f_addr = code_base + ip[addr_w-1:0];

  // ip already stepped past the buffered command
  // a following fetch can only finish once the buffer is drained
  assign cmd_ip = ip;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend      <= 1'b0;
      cmd_valid <= 1'b0;
      ip        <= '0;
    end else begin
      if (f_ack) begin
        pend <= 1'b0;
      end else if (f_req) begin
        pend <= 1'b1;
      end

      // fill on ack, drain on take; both at once keeps it full
      if (f_ack) begin
        cmd_valid <= 1'b1;
        ip        <= ip + opf_pkg::data_w'(1);
      end else if (cmd_ready) begin
        cmd_valid <= 1'b0;
      end
    end
  end

  // one command buffer
  always_ff @(posedge clk) begin
    if (f_ack) begin
      cmd_word <= f_rdata;
    end
  end

endmodule

//--- src/opf_pkg.sv
package opf_pkg;

  // data path and register sizes
  localparam int data_w    = 32;
  localparam int reg_num_w = 4;

  // register 15 reads back as the ip of the next command
  localparam logic [reg_num_w-1:0] reg_ip = 4'd15;

  // register number fields of the command word
  localparam int s1_lsb = 0;
  localparam int s0_lsb = 4;
  localparam int d_lsb  = 8;

  // pointer flags, source read from data memory when set
  localparam int s1_ptr_bit = 16;
  localparam int s0_ptr_bit = 17;

  // two-bit post step fields
  localparam int s1_flag_lsb = 20;
  localparam int s0_flag_lsb = 22;

  // command code in the top nibble
  localparam int code_lsb = 28;
  localparam int code_w   = 4;

  // step codes, 00 and 11 leave the register alone
  localparam logic [1:0] flag_inc = 2'b01;
  localparam logic [1:0] flag_dec = 2'b10;

endpackage
